//--- include/x25519_defs.svh
// X25519 register-file address map and ladder init constants
// Shared by the RTL and the testbench
`ifndef X25519_DEFS_SVH
`define X25519_DEFS_SVH

// Base point and constant words
`define ADR_X_G       5'd0
`define ADR_K_NUM     5'd11
`define ADR_ZRRAM     5'd18
`define ADR_ONERAM    5'd19

// Reserved for the signature datapath
`define ADR_K_INV     5'd12
`define ADR_R_NUM     5'd13
`define ADR_S_NUM     5'd14
`define ADR_HASH      5'd16

// Ladder start words
`define ADR_X2        5'd7
`define ADR_Z2        5'd8
`define ADR_X3        5'd9
`define ADR_Z3        5'd10
`define ADR_A24       5'd31
`define ADR_ACCIDENT  5'd30     // Debug sink for idle write data

// Init values
`define X2_INIT       1
`define Z2_INIT       0
`define Z3_INIT       1
`define A24_VALUE     121665

// Bus layout, word in bits 7..3, lane in bits 2..0
`define CTRL_BASE     9'd256
`define BUS_WORD_MSB  7
`define BUS_WORD_LSB  3
`define BUS_LANE_MSB  2
`define BUS_LANE_LSB  0

`endif

//--- hdl/x25519_pkg.sv
// X25519 engine types, ALU opcodes and init sequencer states

package x25519_pkg;

    typedef logic [255:0] fe_t;         // Field element / RAM word
    typedef logic [4:0]   ram_addr_t;   // Register file address
    typedef logic [3:0]   alu_op_t;
    typedef logic [7:0]   lane_mask_t;  // One bit per 32-bit lane
    typedef logic [31:0]  bus_data_t;
    typedef logic [8:0]   bus_addr_t;   // Wishbone word address

    localparam alu_op_t OP_FA = 4'd4;   // Field add
    localparam alu_op_t OP_FS = 4'd5;   // Field subtract

    // Ladder init sequence
    typedef enum logic [3:0] {
        IDLE, INITX2, INITZ2, INITX3,
        INITX32,                        // Wait ALU result for X3
        INITZ3, INITA24, INITK1,
        INITK2,                         // Wait ALU result for K
        INITK3
    } init_state_t;

endpackage

//--- hdl/field_alu.sv
// Field adder/subtractor mod 2^255-19
// Operands arrive on consecutive cycles, result after ALU_LAT cycles
`timescale 1ns/100ps

module field_alu
    import x25519_pkg::*;
#(
    parameter int ALU_LAT = 2
)
(
    input  logic    clk,
    input  logic    rst,
    input  logic    alu_en,
    input  alu_op_t alu_op,
    input  logic    alu_carry,
    input  fe_t     opd,
    output fe_t     alu_res,
    output logic    alu_vld
);

    // p = 2^255 - 19
    localparam fe_t FIELD_P = {1'b0, {250{1'b1}}, 5'b01101};

    fe_t          opa_q;
    alu_op_t      op_q;
    logic         cin_q;
    logic         opb_phase;        // Operand B on opd this cycle
    logic [256:0] sum;
    logic [256:0] sum_red;
    logic [256:0] diff;
    logic [256:0] diff_fix;
    fe_t          calc;

    fe_t              res_pipe [ALU_LAT];
    logic [ALU_LAT-1:0] vld_pipe;

    //////////////////////////////
    // Operand capture

    always_ff @(posedge clk)
    begin
        if (alu_en)
        begin
            opa_q <= opd;
            op_q  <= alu_op;
            cin_q <= alu_carry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            opb_phase <= 1'b0;
        else
            opb_phase <= alu_en;
    end

    //////////////////////////////
    // Arithmetic, one correction by p

    always_comb
    begin
        sum      = {1'b0, opa_q} + {1'b0, opd} + 257'(cin_q);
        sum_red  = sum - {1'b0, FIELD_P};
        diff     = {1'b0, opa_q} - {1'b0, opd} - 257'(cin_q);  // Carry is borrow in
        diff_fix = diff + {1'b0, FIELD_P};
        if (op_q == OP_FS)
            calc = diff[256] ? diff_fix[255:0] : diff[255:0];
        else
            calc = (sum >= {1'b0, FIELD_P}) ? sum_red[255:0] : sum[255:0];
    end

    //////////////////////////////
    // Latency pipeline

    always_ff @(posedge clk)
    begin
        res_pipe[0] <= calc;          // Loaded as operand B is taken
        for (int i = 1; i < ALU_LAT; i++)
            res_pipe[i] <= res_pipe[i-1];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            vld_pipe <= '0;
        else
        begin
            vld_pipe[0] <= opb_phase;
            for (int i = 1; i < ALU_LAT; i++)
                vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    assign alu_res = res_pipe[ALU_LAT-1];
    assign alu_vld = vld_pipe[ALU_LAT-1];

endmodule

//--- hdl/operand_ram.sv
// 32 x 256-bit operand register file
// Registered read, writes masked per 32-bit lane
`timescale 1ns/100ps

module operand_ram
    import x25519_pkg::*;
(
    input  logic       clk,
    input  ram_addr_t  ra,
    input  ram_addr_t  wa,
    input  logic       we,
    input  lane_mask_t wmask,
    input  fe_t        wd,
    output fe_t        rd
);

    fe_t mem [32];

    // Write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (wmask[i])
                    mem[wa][32*i +: 32] <= wd[32*i +: 32];
            end
        end
    end

    // Read port, old data on a same-address write
    always_ff @(posedge clk)
    begin
        rd <= mem[ra];
    end

endmodule

//--- hdl/ladder_init.sv
// Montgomery ladder init sequencer
// Writes X2, Z2, X3, Z3, A24 and the clamped scalar into the register file
`timescale 1ns/100ps
`include "x25519_defs.svh"

module ladder_init
    import x25519_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      init_en,      // Start pulse from host port
    input  logic      alu_vld,
    input  fe_t       alu_res,
    output logic      init_done,
    output logic      alu_en,
    output alu_op_t   alu_op,
    output logic      alu_carry,
    output ram_addr_t init_ra,
    output ram_addr_t init_wa,
    output logic      init_we,
    output fe_t       init_wd
);

    init_state_t state;
    logic        x32_vld;
    logic        k2_vld;
    fe_t         k_clamp;

    assign x32_vld = (state == INITX32) & alu_vld;
    assign k2_vld  = (state == INITK2) & alu_vld;

    //////////////////////////////
    // FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= IDLE;
            init_done <= 1'b0;
        end
        else
        begin
            init_done <= 1'b0;
            case (state)
                IDLE:    if (init_en) state <= INITX2;
                INITX2:  state <= INITZ2;
                INITZ2:  state <= INITX3;
                INITX3:  state <= INITX32;
                INITX32: if (alu_vld) state <= INITZ3;
                INITZ3:  state <= INITA24;
                INITA24: state <= INITK1;
                INITK1:  state <= INITK2;
                INITK2:  if (alu_vld) state <= INITK3;
                INITK3:
                begin
                    state     <= IDLE;
                    init_done <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // ALU control

    // Only additions with zero here, used to reduce X_G and K
    assign alu_op    = OP_FA;
    assign alu_carry = 1'b0;

    // Operand A is on the read port one cycle after these states
    always_ff @(posedge clk)
    begin
        if (rst)
            alu_en <= 1'b0;
        else
            alu_en <= (state == INITX3) | (state == INITK1);
    end

    // Scalar clamp on the reduced K
    always_ff @(posedge clk)
    begin
        if (k2_vld)
            k_clamp <= {1'b0, 1'b1, alu_res[253:3], 3'b000};
    end

    //////////////////////////////
    // RAM port, registered from state

    always_ff @(posedge clk)
    begin
        if (rst)
            init_we <= 1'b0;
        else
            init_we <= (state == INITX2) | (state == INITZ2) | x32_vld |
                       (state == INITZ3) | (state == INITA24) | (state == INITK3);
    end

    always_ff @(posedge clk)
    begin
        init_wa <= `ADR_ACCIDENT;       // Harmless, we is low
        init_wd <= '0;
        init_ra <= `ADR_ZRRAM;          // Operand B of each addition
        case (state)
            INITX2:
            begin
                init_wa <= `ADR_X2;
                init_wd <= fe_t'(`X2_INIT);
            end
            INITZ2:
            begin
                init_wa <= `ADR_Z2;
                init_wd <= fe_t'(`Z2_INIT);
                init_ra <= `ADR_X_G;    // Ready for INITX3
            end
            INITX32:
            begin
                init_wa <= `ADR_X3;
                init_wd <= alu_res;
            end
            INITZ3:
            begin
                init_wa <= `ADR_Z3;
                init_wd <= fe_t'(`Z3_INIT);
            end
            INITA24:
            begin
                init_wa <= `ADR_A24;
                init_wd <= fe_t'(`A24_VALUE);
                init_ra <= `ADR_K_NUM;  // Ready for INITK1
            end
            INITK3:
            begin
                init_wa <= `ADR_K_NUM;
                init_wd <= k_clamp;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/wb_host_port.sv
// Wishbone classic slave for RAM lanes and the init control register
// Shares the RAM ports with the init sequencer
`timescale 1ns/100ps
`include "x25519_defs.svh"

module wb_host_port
    import x25519_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  bus_addr_t  wb_adr,
    input  bus_data_t  wb_dat_i,
    input  logic [3:0] wb_sel,
    output bus_data_t  wb_dat_o,
    output logic       wb_ack,
    output logic       init_en,
    input  logic       init_done,
    input  ram_addr_t  init_ra,
    input  ram_addr_t  init_wa,
    input  logic       init_we,
    input  fe_t        init_wd,
    output ram_addr_t  ram_ra,
    output ram_addr_t  ram_wa,
    output logic       ram_we,
    output lane_mask_t ram_wmask,
    output fe_t        ram_wd,
    input  fe_t        ram_rd
);

    logic       busy;
    logic       done;
    logic       rd_pend;            // RAM read data arrives next cycle
    logic       req;
    logic       is_ctrl;
    logic       ram_go;
    logic       bus_wr;
    logic       start;
    ram_addr_t  bus_word;
    logic [2:0] bus_lane;
    lane_mask_t bus_mask;

    //////////////////////////////
    // Decode

    assign bus_word = wb_adr[`BUS_WORD_MSB:`BUS_WORD_LSB];
    assign bus_lane = wb_adr[`BUS_LANE_MSB:`BUS_LANE_LSB];
    assign bus_mask = lane_mask_t'(1) << bus_lane;

    assign req     = wb_cyc & wb_stb & ~wb_ack & ~rd_pend;   // New access
    assign is_ctrl = wb_adr >= `CTRL_BASE;
    assign ram_go  = req & ~is_ctrl & ~busy;                  // Held off while busy
    assign bus_wr  = ram_go & wb_we & (|wb_sel);
    assign start   = req & is_ctrl & wb_we & wb_sel[0] & wb_dat_i[0] & ~busy;

    //////////////////////////////
    // Handshake and status

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack  <= 1'b0;
            rd_pend <= 1'b0;
            init_en <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            wb_ack  <= (req & is_ctrl) | (ram_go & wb_we) | rd_pend;
            rd_pend <= ram_go & ~wb_we;
            init_en <= start;
            if (start)
            begin
                busy <= 1'b1;
                done <= 1'b0;           // Sticky until next start
            end
            else if (init_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req & is_ctrl & ~wb_we)
            wb_dat_o <= bus_data_t'({done, busy});
        else if (rd_pend)
            wb_dat_o <= ram_rd[{bus_lane, 5'b00000} +: 32];
    end

    //////////////////////////////
    // RAM port mux

    assign ram_ra    = busy ? init_ra : bus_word;
    assign ram_wa    = busy ? init_wa : bus_word;
    assign ram_we    = busy ? init_we : bus_wr;
    assign ram_wmask = busy ? lane_mask_t'('1) : bus_mask;
    assign ram_wd    = busy ? init_wd : {8{wb_dat_i}};   // Lane copied to every slice

endmodule

//--- hdl/x25519_core.sv
// X25519 engine setup stage
// Bus port, operand RAM, field ALU and ladder init sequencer
`timescale 1ns/100ps

module x25519_core
    import x25519_pkg::*;
#(
    parameter int ALU_LAT = 2
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  bus_addr_t  wb_adr,
    input  bus_data_t  wb_dat_i,
    input  logic [3:0] wb_sel,
    output bus_data_t  wb_dat_o,
    output logic       wb_ack
);

    // Sequencer side
    logic       init_en;
    logic       init_done;
    ram_addr_t  init_ra;
    ram_addr_t  init_wa;
    logic       init_we;
    fe_t        init_wd;

    // RAM side
    ram_addr_t  ram_ra;
    ram_addr_t  ram_wa;
    logic       ram_we;
    lane_mask_t ram_wmask;
    fe_t        ram_wd;
    fe_t        ram_rd;

    // ALU
    logic       alu_en;
    alu_op_t    alu_op;
    logic       alu_carry;
    fe_t        alu_res;
    logic       alu_vld;

    wb_host_port u_host (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_sel,
        .wb_dat_o, .wb_ack,
        .init_en, .init_done, .init_ra, .init_wa, .init_we, .init_wd,
        .ram_ra, .ram_wa, .ram_we, .ram_wmask, .ram_wd, .ram_rd
    );

    operand_ram u_ram (
        .clk,
        .ra    (ram_ra),
        .wa    (ram_wa),
        .we    (ram_we),
        .wmask (ram_wmask),
        .wd    (ram_wd),
        .rd    (ram_rd)
    );

    field_alu #(.ALU_LAT(ALU_LAT)) u_alu (
        .clk, .rst,
        .alu_en, .alu_op, .alu_carry,
        .opd   (ram_rd),             // Operands straight off the read port
        .alu_res, .alu_vld
    );

    ladder_init u_init (
        .clk, .rst,
        .init_en, .alu_vld, .alu_res,
        .init_done, .alu_en, .alu_op, .alu_carry,
        .init_ra, .init_wa, .init_we, .init_wd
    );

endmodule

//--- testbench/x25519_props.sv
// Bound checks on the bus handshake and the init write sequence
`timescale 1ns/100ps

module x25519_props
    import x25519_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic        init_we,
    input logic        init_done,
    input init_state_t state
);

    // Ack only answers a live strobe
    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
        else $error("wb_ack high without wb_stb");

    // Only the final scalar write may land in IDLE, together with done
    no_we_in_idle: assert property (@(posedge clk) disable iff (rst)
        (init_we && state == IDLE) |-> init_done)
        else $error("init_we high in IDLE outside the final write");

    done_is_pulse: assert property (@(posedge clk) disable iff (rst) init_done |=> !init_done)
        else $error("init_done longer than one cycle");

endmodule

bind wb_host_port x25519_props u_bus_props (
    .clk, .rst, .wb_stb, .wb_ack,
    .init_we   (1'b0),
    .init_done (1'b0),
    .state     (x25519_pkg::IDLE)
);

bind ladder_init x25519_props u_init_props (
    .clk, .rst,
    .wb_stb (1'b1),
    .wb_ack (1'b0),
    .init_we, .init_done, .state
);

//--- testbench/tb_x25519.sv
// Testbench for the X25519 setup stage
// Loads operands over Wishbone, runs ladder init and checks the start words
`timescale 1ns/100ps
`include "x25519_defs.svh"

module tb_x25519
    import x25519_pkg::*;
;

    localparam int SEED     = 49772;
    localparam int RST_CYC  = 16;
    localparam int VEC_TIME = 2000;    // ns per test slot
    localparam fe_t FIELD_P = {1'b0, {250{1'b1}}, 5'b01101};

    logic       clk = 1'b0;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    bus_addr_t  wb_adr;
    bus_data_t  wb_dat_i;
    logic [3:0] wb_sel;
    bus_data_t  wb_dat_o;
    logic       wb_ack;

    fe_t k_q[$];
    fe_t xg_q[$];
    fe_t ek_q[$];
    fe_t ex_q[$];
    int  n_vec = 0;
    logic tests_loaded = 1'b0;

    x25519_core #(.ALU_LAT(2)) uut (.*);

    always #4 clk = ~clk;

    //////////////////////////////
    // Bus access tasks called 1 ns after a rising edge

    task automatic bus_write(input bus_addr_t adr, input bus_data_t dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        do @(negedge clk); while (!wb_ack);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t adr, output bus_data_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge clk); while (!wb_ack);
        dat = wb_dat_o;                 // Stable mid cycle
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    function automatic bus_addr_t lane_adr(input ram_addr_t word, input int lane);
        return {1'b0, word, 3'(lane)};
    endfunction

    task automatic write_word(input ram_addr_t word, input fe_t v);
        for (int i = 0; i < 8; i++)
            bus_write(lane_adr(word, i), v[32*i +: 32]);
    endtask

    task automatic read_word(input ram_addr_t word, output fe_t v);
        bus_data_t d;
        for (int i = 0; i < 8; i++)
        begin
            bus_read(lane_adr(word, i), d);
            v[32*i +: 32] = d;
        end
    endtask

    //////////////////////////////
    // Reference rules and checking

    function automatic fe_t clamp_scalar(input fe_t k);
        fe_t c;
        c      = k;
        c[255] = 1'b0;
        c[254] = 1'b1;
        c[2:0] = 3'b000;
        return c;
    endfunction

    // Full reduction mod p
    function automatic fe_t reduce_p(input fe_t x);
        return x % FIELD_P;
    endfunction

    task automatic check(input string name, input fe_t exp, input fe_t act);
        if (exp !== act)
        begin
            $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input ram_addr_t word, input fe_t exp);
        fe_t v;
        read_word(word, v);
        check(name, exp, v);
    endtask

    //////////////////////////////
    // Watchdog with one extra slot for the filler words

    initial
    begin
        int limit;
        wait (tests_loaded);
        limit = (n_vec + 1) * VEC_TIME + RST_CYC * 8;
        #(limit);
        $display("Timeout: simulation did not finish within %0d ns", limit);
        $display("Something failed");
        $fatal(1);
    end

    initial
    begin
        int         fd;
        int         n;
        string      line;
        fe_t        k, xg, ek, ex, v;
        bus_data_t  st;
        ram_addr_t  fill_adr[3];
        fe_t        fill_val[3];

        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        wb_sel   = 4'hf;
        void'($urandom(SEED));

        fd = $fopen("testbench/x25519_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test vector file");
            $display("Something failed");
            $fatal(1);
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#" && $sscanf(line, "%h %h %h %h", k, xg, ek, ex) == 4)
            begin
                k_q.push_back(k);
                xg_q.push_back(xg);
                ek_q.push_back(ek);
                ex_q.push_back(ex);
            end
        end
        $fclose(fd);
        n_vec = k_q.size();
        tests_loaded = 1'b1;

        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        bus_read(`CTRL_BASE, st);
        check("status after reset", fe_t'(0), fe_t'(st));

        // Filler words in unused addresses
        fill_adr[0] = 5'd1;
        fill_adr[1] = 5'd15;
        fill_adr[2] = 5'd25;
        for (int w = 0; w < 3; w++)
        begin
            for (int i = 0; i < 8; i++)
                fill_val[w][32*i +: 32] = $urandom;
            write_word(fill_adr[w], fill_val[w]);
        end
        for (int w = 0; w < 3; w++)
            check_word("filler word", fill_adr[w], fill_val[w]);

        for (int t = 0; t < n_vec; t++)
        begin
            check("vector clamped K", clamp_scalar(k_q[t]), ek_q[t]);
            check("vector reduced X_G", reduce_p(xg_q[t]), ex_q[t]);
            write_word(`ADR_ZRRAM, '0);
            write_word(`ADR_ONERAM, fe_t'(1));
            write_word(`ADR_X_G, xg_q[t]);
            write_word(`ADR_K_NUM, k_q[t]);

            bus_write(`CTRL_BASE, 32'h1);
            bus_read(lane_adr(`ADR_K_NUM, 0), st);      // Held off until init ends
            check("K_NUM lane 0 read during init", fe_t'(ek_q[t][31:0]), fe_t'(st));
            bus_read(`CTRL_BASE, st);
            check("status after held read", fe_t'(2), fe_t'(st));
            do bus_read(`CTRL_BASE, st); while (st[1] == 1'b0);

            check_word("X2", `ADR_X2, fe_t'(`X2_INIT));
            check_word("Z2", `ADR_Z2, fe_t'(`Z2_INIT));
            check_word("X3", `ADR_X3, ex_q[t]);
            check_word("Z3", `ADR_Z3, fe_t'(`Z3_INIT));
            check_word("A24", `ADR_A24, fe_t'(`A24_VALUE));
            read_word(`ADR_K_NUM, v);
            check("K_NUM", ek_q[t], v);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- testbench/x25519_tests.txt
# Columns, all hex: K, X_G, expected clamped K_NUM, expected X3 = X_G mod 2^255-19
# K stays below p so the adder pass leaves it unchanged
1234567890abcdef 9 4000000000000000000000000000000000000000000000001234567890abcde8 9
3fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff8 0
4000000000000000000000000000000000000000000000000000000000000007 7ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff2 4000000000000000000000000000000000000000000000000000000000000000 5
55 8000000000000000000000000000000000000000000000000000000000000064 4000000000000000000000000000000000000000000000000000000000000050 77

//--- all.f
+incdir+include
hdl/x25519_pkg.sv
hdl/field_alu.sv
hdl/operand_ram.sv
hdl/ladder_init.sv
hdl/wb_host_port.sv
hdl/x25519_core.sv
testbench/x25519_props.sv
testbench/tb_x25519.sv

//--- run.sh
#!/bin/sh
# Build and run the X25519 setup stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_x25519 \
    -o sim_tb

./obj_dir/sim_tb
